//--- sim/lsu_trace.txt
# Header: 16 memory words. Records: op(0 ld 1 st 2 ld err) opa opb incr size(0 b 1 h 2 w)
# sign wdata exp_be exp_bus_wdata exp_misaligned exp_result(load data or error address)
83810201 44F3A255 99887766 00FF7F80
13121110 17161514 1B1A1918 1F1E1D1C
23222120 27262524 2B2A2928 2F2E2D2C
33323130 37363534 3B3A3938 3F3E3D3C
0 00000000 00000000 0 0 1 00000000 1 00000000 0 00000001
0 00000002 00000000 0 0 1 00000000 4 00000000 0 FFFFFF81
0 00000003 00000000 0 0 0 00000000 8 00000000 0 00000083
0 00000004 00000001 1 0 1 00000000 2 00000000 0 FFFFFFA2
0 00000006 00000000 0 1 1 00000000 C 00000000 0 000044F3
0 0000000A 00000000 0 1 1 00000000 C 00000000 0 FFFF9988
0 0000000E 00000000 0 1 0 00000000 C 00000000 0 000000FF
0 0000000C 00000000 0 1 1 00000000 3 00000000 0 00007F80
0 00000008 00000004 0 2 0 00000000 F 00000000 0 99887766
0 00000004 00000008 1 2 0 00000000 F 00000000 0 00FF7F80
0 00000005 00000000 0 2 0 00000000 E 00000000 1 6644F3A2
0 0000000B 00000000 0 1 1 00000000 8 00000000 1 FFFF8099
0 0000000E 00000000 0 2 0 00000000 C 00000000 1 111000FF
1 00000011 00000000 0 0 0 000000AB 2 0000AB00 0 00000000
0 00000011 00000000 0 0 0 00000000 2 00000000 0 000000AB
1 00000016 00000000 0 1 0 0000CDEF C CDEF0000 0 00000000
0 00000016 00000000 0 1 0 00000000 C 00000000 0 0000CDEF
1 00000018 00000000 0 2 0 DEADBEEF F DEADBEEF 0 00000000
0 00000018 00000000 0 2 0 00000000 F 00000000 0 DEADBEEF
1 0000001D 00000000 0 2 0 12345678 E 34567812 1 00000000
0 0000001D 00000000 0 2 0 00000000 E 00000000 1 12345678
1 00000023 00000000 0 1 0 0000BEAD 8 AD0000BE 1 00000000
0 00000023 00000000 0 1 1 00000000 8 00000000 1 FFFFBEAD
2 80000010 00000000 0 2 0 00000000 F 00000000 0 80000010

//--- verilog.f
+incdir+src
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_align.sv
src/lsu_txn_ctrl.sv
src/lsu_top.sv
sim/tb_lsu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f verilog.f --top-module tb_lsu -o tb_lsu
	./obj_dir/tb_lsu | grep "sim passed"

clean:
	rm -rf obj_dir

//--- sim/tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu import lsu_pkg::*;
();

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic lsu_en_i = 1'b0, we_i = 1'b0, sign_ext_i = 1'b0, use_incr_i = 1'b0;
  logic misaligned_phase_i = 1'b0;
  lsu_type_e type_i = LSU_BYTE;
  logic [`LSU_XLEN-1:0] operand_a_i = '0, operand_b_i = '0, wdata_i = '0;
  logic ex_ready_o, ex_valid_o, misaligned_o, wb_valid_o, err_o, busy_o;
  logic [`LSU_XLEN-1:0] rdata_o, err_addr_o, data_addr_o, data_wdata_o;
  logic data_req_o, data_we_o;
  logic [`LSU_BE_W-1:0] data_be_o;
  logic data_gnt_i = 1'b0, data_rvalid_i = 1'b0, data_err_i = 1'b0;
  logic [`LSU_XLEN-1:0] data_rdata_i = '0;

  logic [31:0] mem [0:15];                 // Bus memory model, word indexed
  integer seed = 32'he9d9_8ab2;
  // Current trace record
  logic [31:0] op, opa, opb, wd, exp_wdata, exp_res;
  logic [3:0]  exp_be;
  logic [1:0]  size;
  logic        incr, sgn, exp_mis;

  lsu_top uut (.*);

  always #10 clk = ~clk;                   // 20 ns period

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input string tn, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %h actual %h", tn, exp, act);
      $display("sim failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_be(input string tn, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %b actual %b", tn, exp, act);
      $display("sim failed");
      $fatal(1, "byte enable mismatch");
    end
  endtask

  task automatic check_type(input string tn, input lsu_type_e exp, input lsu_type_e act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %s actual %s", tn, exp.name(), act.name());
      $display("sim failed");
      $fatal(1, "size mismatch");
    end
  endtask

  task automatic check_bit(input string tn, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %b actual %b", tn, exp, act);
      $display("sim failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("sim failed");
    $fatal(1, "timeout");
  endtask

  //////////////////////////////
  // One bus access
  //////////////////////////////

  // Issues one phase, grants it at random, answers 1 to 3 cycles later
  task automatic do_access(input int ln, input logic ph2, input logic [31:0] a);
    string tn;
    int waits;
    int delay;
    logic [31:0] rnd, ea, gaddr;
    logic last;
    tn = $sformatf("line %0d phase %0d", ln, ph2);
    ea = incr ? a + opb : a;                    // Increment only when selected
    last = exp_mis ? ph2 : 1'b1;                // Split instruction ends on its second phase
    lsu_en_i = 1'b1;
    we_i = (op == 32'd1);
    type_i = lsu_type_e'(size);
    sign_ext_i = sgn;
    use_incr_i = incr;
    misaligned_phase_i = ph2;
    operand_a_i = a;
    operand_b_i = opb;
    wdata_i = wd;
    data_gnt_i = 1'b0;                          // First cycle always stalled
    waits = 0;
    @(posedge clk);
    while (!(data_req_o && data_gnt_i))
    begin
      check_bit({tn, " req held"}, 1'b1, data_req_o);
      check_bit({tn, " ex_ready stalled"}, 1'b0, ex_ready_o);
      check_bit({tn, " ex_valid stalled"}, 1'b0, ex_valid_o);
      check_bit({tn, " busy stalled"}, 1'b1, busy_o);
      waits++;
      if (waits > 50)
        report_timeout("no grant on the data bus");
      @(negedge clk);
      rnd = $random(seed);
      data_gnt_i = rnd[0];
      @(posedge clk);
    end
    // Grant cycle
    check_bit({tn, " ex_ready"}, 1'b1, ex_ready_o);
    check_bit({tn, " ex_valid"}, 1'b1, ex_valid_o);
    check_bit({tn, " we"}, (op == 32'd1), data_we_o);
    check_word({tn, " addr"}, ph2 ? {ea[31:2], 2'b00} : ea, data_addr_o);
    check_bit({tn, " misaligned"}, ph2 ? 1'b0 : exp_mis, misaligned_o);
    if (!ph2)
    begin
      check_be({tn, " be"}, exp_be, data_be_o);
      check_word({tn, " wdata"}, exp_wdata, data_wdata_o);
    end
    gaddr = data_addr_o;
    if (data_we_o && gaddr < 32'h8000_0000)
      for (int i = 0; i < 4; i++)
        if (data_be_o[i])
          mem[gaddr[5:2]][8*i +: 8] = data_wdata_o[8*i +: 8];
    @(negedge clk);
    lsu_en_i = 1'b0;
    data_gnt_i = 1'b0;
    rnd = $random(seed);
    delay = 1 + int'(rnd[1:0] % 2'd3);
    for (int i = 1; i < delay; i++)            // Response latency of the model
    begin
      @(posedge clk);
      check_bit({tn, " busy open"}, 1'b1, busy_o);
      @(negedge clk);
    end
    data_rvalid_i = 1'b1;
    data_err_i    = (gaddr >= 32'h8000_0000);
    data_rdata_i  = data_err_i ? 32'h0 : mem[gaddr[5:2]];
    @(posedge clk);
    check_bit({tn, " wb_valid"}, last, wb_valid_o);
    check_bit({tn, " err"}, (op == 32'd2), err_o);
    check_type({tn, " wb size"}, lsu_type_e'(size), uut.type_q);
    if (op == 32'd2)
      check_word({tn, " err_addr"}, exp_res, err_addr_o);
    else if (last && op == 32'd0)
      check_word({tn, " rdata"}, exp_res, rdata_o);
    @(negedge clk);
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    @(posedge clk);
    check_bit({tn, " idle"}, 1'b0, busy_o);
    check_bit({tn, " idle ex_ready"}, 1'b1, ex_ready_o);
    check_bit({tn, " idle ex_valid"}, 1'b0, ex_valid_o);
    @(negedge clk);
  endtask

  //////////////////////////////
  // Trace driven run
  //////////////////////////////

  initial
  begin
    int fd;
    int code;
    int ln;
    string skip;
    ln = 0;
    fd = $fopen("sim/lsu_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Trace file could not be opened");
      $display("sim failed");
      $fatal(1, "no trace");
    end
    code = $fgets(skip, fd);                   // Two column description lines
    code = $fgets(skip, fd);
    for (int i = 0; i < 16; i++)
      code = $fscanf(fd, "%h", mem[i]);
    repeat (8) @(posedge clk);                 // Reset for 8 cycles
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", op, opa, opb, incr, size,
                   sgn, wd, exp_be, exp_wdata, exp_mis, exp_res);
    while (code == 11)
    begin
      ln++;
      do_access(ln, 1'b0, opa);
      if (exp_mis)
        do_access(ln, 1'b1, opa + 32'd4);      // Requester moves to the next word
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", op, opa, opb, incr, size,
                     sgn, wd, exp_be, exp_wdata, exp_mis, exp_res);
    end
    $fclose(fd);
    if (ln == 0)
    begin
      $display("Trace held no records");
      $display("sim failed");
      $fatal(1, "empty trace");
    end
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Pipeline request
  input  logic                  lsu_en_i,
  input  logic                  we_i,
  input  lsu_type_e             type_i,
  input  logic                  sign_ext_i,
  input  logic                  use_incr_i,
  input  logic                  misaligned_phase_i,
  input  logic [`LSU_XLEN-1:0]  operand_a_i,
  input  logic [`LSU_XLEN-1:0]  operand_b_i,
  input  logic [`LSU_XLEN-1:0]  wdata_i,
  // Pipeline status
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  misaligned_o,
  output logic                  wb_valid_o,
  output logic [`LSU_XLEN-1:0]  rdata_o,
  output logic                  err_o,
  output logic [`LSU_XLEN-1:0]  err_addr_o,
  output logic                  busy_o,
  // Data bus
  output logic                  data_req_o,
  output logic [`LSU_XLEN-1:0]  data_addr_o,
  output logic                  data_we_o,
  output logic [`LSU_BE_W-1:0]  data_be_o,
  output logic [`LSU_XLEN-1:0]  data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`LSU_XLEN-1:0]  data_rdata_i,
  input  logic                  data_err_i
);

  logic [`LSU_XLEN-1:0] addr;        // Unaligned byte address
  logic                 misaligned;
  lsu_type_e            type_q;
  logic                 sign_ext_q;
  logic                 we_q;
  logic [1:0]           offset_q;
  logic                 split_first;

  assign data_we_o    = we_i;
  assign misaligned_o = misaligned;

  lsu_store_align u_store
  (
    .lsu_en_i           (lsu_en_i),
    .we_i               (we_i),
    .type_i             (type_i),
    .use_incr_i         (use_incr_i),
    .misaligned_phase_i (misaligned_phase_i),
    .operand_a_i        (operand_a_i),
    .operand_b_i        (operand_b_i),
    .wdata_i            (wdata_i),
    .addr_o             (addr),
    .bus_addr_o         (data_addr_o),
    .be_o               (data_be_o),
    .bus_wdata_o        (data_wdata_o),
    .misaligned_o       (misaligned)
  );

  lsu_txn_ctrl u_ctrl
  (
    .clk                (clk),
    .rst_n              (rst_n),
    .lsu_en_i           (lsu_en_i),
    .we_i               (we_i),
    .type_i             (type_i),
    .sign_ext_i         (sign_ext_i),
    .misaligned_i       (misaligned),
    .misaligned_phase_i (misaligned_phase_i),
    .addr_i             (addr),
    .bus_addr_i         (data_addr_o),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_err_i         (data_err_i),
    .data_req_o         (data_req_o),
    .ex_ready_o         (ex_ready_o),
    .ex_valid_o         (ex_valid_o),
    .wb_valid_o         (wb_valid_o),
    .busy_o             (busy_o),
    .err_o              (err_o),
    .err_addr_o         (err_addr_o),
    .type_q_o           (type_q),
    .sign_ext_q_o       (sign_ext_q),
    .we_q_o             (we_q),
    .offset_q_o         (offset_q),
    .split_first_o      (split_first)
  );

  lsu_load_align u_load
  (
    .clk                (clk),
    .rst_n              (rst_n),
    .data_rvalid_i      (data_rvalid_i),
    .data_rdata_i       (data_rdata_i),
    .type_q_i           (type_q),
    .sign_ext_q_i       (sign_ext_q),
    .we_q_i             (we_q),
    .offset_q_i         (offset_q),
    .split_first_i      (split_first),
    .rdata_o            (rdata_o)
  );

endmodule

//--- src/lsu_txn_ctrl.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_txn_ctrl import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lsu_en_i,           // Request held in EX
  input  logic                  we_i,
  input  lsu_type_e             type_i,
  input  logic                  sign_ext_i,
  input  logic                  misaligned_i,       // First phase of a split access
  input  logic                  misaligned_phase_i, // Second phase of a split access
  input  logic [`LSU_XLEN-1:0]  addr_i,             // Byte address
  input  logic [`LSU_XLEN-1:0]  bus_addr_i,         // Address on the bus
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  output logic                  data_req_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  wb_valid_o,
  output logic                  busy_o,
  output logic                  err_o,
  output logic [`LSU_XLEN-1:0]  err_addr_o,         // Address of the last grant
  output lsu_type_e             type_q_o,
  output logic                  sign_ext_q_o,
  output logic                  we_q_o,
  output logic [1:0]            offset_q_o,
  output logic                  split_first_o       // WB holds first phase of a split load
);

  logic [`LSU_CNT_W-1:0] cnt_q;     // Outstanding transactions
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;  // Grant accepted
  logic                  count_down; // Response received
  logic                  ctrl_update; // EX hands its access to WB
  logic                  last_d;
  logic                  last_q;    // WB access completes the instruction

  //////////////////////////////
  // Request and handshakes
  //////////////////////////////

  assign data_req_o = lsu_en_i && (cnt_q < `LSU_MAX_OUTSTANDING);
  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  // EX and WB advance in lock step once WB is occupied
  always_comb
  begin
    if (!lsu_en_i)
      ex_ready_o = 1'b1;                      // Nothing to do
    else if (cnt_q == '0)
      ex_ready_o = count_up;
    else if (cnt_q == `LSU_CNT_W'd1)
      ex_ready_o = count_up && data_rvalid_i; // WB must drain in the same cycle
    else
      ex_ready_o = data_rvalid_i;             // Already granted, wait for oldest response
  end

  assign ex_valid_o  = lsu_en_i && ex_ready_o;
  assign ctrl_update = lsu_en_i && ex_ready_o;

  assign wb_valid_o = (cnt_q != '0) && last_q && data_rvalid_i; // Last phase only
  assign err_o      = data_rvalid_i && data_err_i;
  assign busy_o     = (cnt_q != '0) || data_req_o;

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;               // Idle or grant with response
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  //////////////////////////////
  // Writeback control
  //////////////////////////////

  // Only a first phase leaves the instruction unfinished
  assign last_d = !(misaligned_i && !misaligned_phase_i);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q_o     <= LSU_BYTE;
      sign_ext_q_o <= 1'b0;
      we_q_o       <= 1'b0;
      offset_q_o   <= 2'b00;
      last_q       <= 1'b0;
    end
    else if (ctrl_update)
    begin
      type_q_o     <= type_i;
      sign_ext_q_o <= sign_ext_i;
      we_q_o       <= we_i;
      offset_q_o   <= addr_i[1:0];   // Same offset on both phases
      last_q       <= last_d;
    end
  end

  assign split_first_o = !last_q && !we_q_o;

  // Error address tracks every grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      err_addr_o <= '0;
    else if (count_up)
      err_addr_o <= bus_addr_i;
  end

  // Bus must never see more open requests than the LSU allows
  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_MAX_OUTSTANDING);

  // Every response needs a granted request ahead of it
  a_rvalid_open: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

endmodule

//--- src/lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_align import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_rvalid_i,  // Response valid from the bus
  input  logic [`LSU_XLEN-1:0]  data_rdata_i,   // Raw response word
  input  lsu_type_e             type_q_i,       // Size of the access in WB
  input  logic                  sign_ext_q_i,   // Sign extend result
  input  logic                  we_q_i,         // Access in WB is a store
  input  logic [1:0]            offset_q_i,     // Byte offset of the access
  input  logic                  split_first_i,  // Response is first phase of a split load
  output logic [`LSU_XLEN-1:0]  rdata_o         // Result to the register file
);

  logic [`LSU_XLEN-1:0] rdata_q;    // First phase word or last result
  logic [`LSU_XLEN-1:0] rdata_w;    // Word, assembled when split
  logic [15:0]          rdata_h;    // Halfword before extension
  logic [7:0]           rdata_b;    // Byte before extension
  logic [`LSU_XLEN-1:0] rdata_ext;

  //////////////////////////////
  // Lane extraction
  //////////////////////////////

  // Split words take their low bytes from the held first response
  always_comb
  begin
    case (offset_q_i)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[ 7:0], rdata_q[31: 8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_q_i)
      2'b00:   rdata_h = data_rdata_i[15: 0];
      2'b01:   rdata_h = data_rdata_i[23: 8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]}; // Split halfword
    endcase
  end

  always_comb
  begin
    case (offset_q_i)
      2'b00:   rdata_b = data_rdata_i[ 7: 0];
      2'b01:   rdata_b = data_rdata_i[15: 8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      default: rdata_b = data_rdata_i[31:24];
    endcase
  end

  //////////////////////////////
  // Sign extension
  //////////////////////////////

  always_comb
  begin
    case (type_q_i)
      LSU_BYTE: rdata_ext = {{24{sign_ext_q_i & rdata_b[7]}}, rdata_b};
      LSU_HALF: rdata_ext = {{16{sign_ext_q_i & rdata_h[15]}}, rdata_h};
      default:  rdata_ext = rdata_w;
    endcase
  end

  // Holding register
  // Raw word on the first phase of a split, final result otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (data_rvalid_i && !we_q_i) // Stores leave the last load result intact
    begin
      if (split_first_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // Live response when present, held value between responses
  assign rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

//--- src/lsu_store_align.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_store_align import lsu_pkg::*;
(
  input  logic                  lsu_en_i,           // Request present in EX
  input  logic                  we_i,               // Store when high
  input  lsu_type_e             type_i,             // Access size
  input  logic                  use_incr_i,         // Address is A plus B
  input  logic                  misaligned_phase_i, // Second access of a split transfer
  input  logic [`LSU_XLEN-1:0]  operand_a_i,
  input  logic [`LSU_XLEN-1:0]  operand_b_i,
  input  logic [`LSU_XLEN-1:0]  wdata_i,            // Store data, LSB aligned
  output logic [`LSU_XLEN-1:0]  addr_o,             // Byte address of the access
  output logic [`LSU_XLEN-1:0]  bus_addr_o,         // Address placed on the bus
  output logic [`LSU_BE_W-1:0]  be_o,
  output logic [`LSU_XLEN-1:0]  bus_wdata_o,
  output logic                  misaligned_o        // First phase needs a second access
);

  logic [`LSU_XLEN-1:0] addr;
  logic [1:0]           offset;     // Byte lane of the first byte
  logic [`LSU_XLEN-1:0] wdata_rot;

  //////////////////////////////
  // Address generation
  //////////////////////////////

  assign addr   = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offset = addr[1:0];
  assign addr_o = addr;

  // Second phase continues in the next word from lane 0
  assign bus_addr_o = misaligned_phase_i ? {addr[`LSU_XLEN-1:2], 2'b00} : addr;

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb
  begin
    case (type_i)
      LSU_BYTE:
      begin
        be_o = 4'b0001 << offset;          // Single lane
      end
      LSU_HALF:
      begin
        if (misaligned_phase_i)
          be_o = 4'b0001;                  // Upper byte spills into lane 0
        else if (offset == 2'b11)
          be_o = 4'b1000;                  // Lower byte only in this word
        else
          be_o = 4'b0011 << offset;
      end
      default:
      begin
        if (misaligned_phase_i)
          be_o = ~(4'b1111 << offset);     // Remaining low lanes
        else
          be_o = 4'b1111 << offset;        // Lanes from offset upwards
      end
    endcase
  end

  //////////////////////////////
  // Write data rotation
  //////////////////////////////

  // Rotate left by the byte offset so each byte lands on its lane
  // The same rotation serves both phases of a split store
  always_comb
  begin
    case (offset)
      2'b00:   wdata_rot = wdata_i;
      2'b01:   wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_rot = {wdata_i[ 7:0], wdata_i[31: 8]};
    endcase
  end

  assign bus_wdata_o = we_i ? wdata_rot : '0; // Quiet bus on loads

  //////////////////////////////
  // Misalignment detection
  //////////////////////////////

  always_comb
  begin
    misaligned_o = 1'b0;
    if (lsu_en_i && !misaligned_phase_i)
    begin
      case (type_i)
        LSU_WORD: misaligned_o = (offset != 2'b00);   // Any offset crosses the word
        LSU_HALF: misaligned_o = (offset == 2'b11);   // Only the top lane crosses
        default:  misaligned_o = 1'b0;                // Bytes never cross
      endcase
    end
  end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

  // Access size as delivered by the decoder
  // Encoding matches the funct3[1:0] field of loads and stores
  typedef enum logic [1:0]
  {
    LSU_BYTE = 2'b00, // 8 bit access
    LSU_HALF = 2'b01, // 16 bit access
    LSU_WORD = 2'b10  // 32 bit access
  } lsu_type_e;

  // 2'b11 is never issued and falls back to word handling
  // in the alignment logic

endpackage

//--- src/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define LSU_XLEN 32 // Address and data width
`define LSU_BE_W 4  // One enable per byte lane

//////////////////////////////
// Transaction depth
//////////////////////////////

// Bus may hold this many granted requests without a response
`define LSU_MAX_OUTSTANDING 2
`define LSU_CNT_W           2 // Counter must reach LSU_MAX_OUTSTANDING

`endif
